//--- build.f
source/datapathPkg.sv
source/selectEncode.sv
source/registerFile.sv
source/busMux.sv
source/alu.sv
source/specialRegisters.sv
source/memoryInterface.sv
source/datapath.sv
test/datapath_chk.sv
test/datapathTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= datapathTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- test/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTb;
    localparam int readTimeout = 8;   // ack delay is at most 3 cycles.
    localparam logic [4:0] opList [13] = '{datapathPkg::opAdd, datapathPkg::opSub,
        datapathPkg::opAnd, datapathPkg::opOr, datapathPkg::opShr, datapathPkg::opShra,
        datapathPkg::opShl, datapathPkg::opRor, datapathPkg::opRol, datapathPkg::opMul,
        datapathPkg::opDiv, datapathPkg::opNeg, datapathPkg::opNot};

    logic Clock = 1'b0;
    logic rstN;
    logic gra, grb, grc, rIn, rOut, pcIn, pcOut, irIn, yIn, zIn, zHighOut, zLowOut;
    logic hiIn, hiOut, loIn, loOut, marIn, mdrIn, mdrOut, cOut, incPc, read;
    logic [4:0] opcode;
    logic [31:0] wbDatIn = '0;
    logic wbAck = 1'b0;
    logic [31:0] busData;
    logic [31:0] wbAdr;
    logic wbCyc, wbStb, memBusy;
    logic [31:0] preload [logic [31:0]];   // words that replace the fill pattern.
    logic [31:0] pcModel = '0;
    logic [31:0] regModel [3];
    int ackDelay = 0;

    datapath UUT (.*);

    always #20 Clock = ~Clock;

    function automatic logic [31:0] memWord(input logic [31:0] addr);
        if (preload.exists(addr)) return preload[addr];
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [63:0] aluModel(input logic [4:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic signed [63:0] wa;
        logic signed [63:0] wb;
        logic [63:0] q;
        logic [63:0] r;
        wa = {{32{a[31]}}, a};
        wb = {{32{b[31]}}, b};
        q = '1;
        r = wa;   // zero divisor keeps the dividend.
        if (b != 0) begin
            q = wa / wb;
            r = wa % wb;
        end
        case (op)
            datapathPkg::opAdd: return {32'b0, a + b};
            datapathPkg::opSub: return {32'b0, a - b};
            datapathPkg::opAnd: return {32'b0, a & b};
            datapathPkg::opOr: return {32'b0, a | b};
            datapathPkg::opShr: return {32'b0, a >> b[4:0]};
            datapathPkg::opShra: return {32'b0, $signed(a) >>> b[4:0]};
            datapathPkg::opShl: return {32'b0, a << b[4:0]};
            datapathPkg::opRor: return {32'b0, (a >> b[4:0]) | (a << (6'd32 - {1'b0, b[4:0]}))};
            datapathPkg::opRol: return {32'b0, (a << b[4:0]) | (a >> (6'd32 - {1'b0, b[4:0]}))};
            datapathPkg::opMul: return wa * wb;
            datapathPkg::opDiv: return {r[31:0], q[31:0]};
            datapathPkg::opNeg: return {32'b0, -b};
            datapathPkg::opNot: return {32'b0, ~b};
            default: return '0;
        endcase
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        $display("SIMULATION FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic clearStrobes();
        {gra, grb, grc, rIn, rOut, pcIn, pcOut, irIn, yIn, zIn, zHighOut, zLowOut} = '0;
        {hiIn, hiOut, loIn, loOut, marIn, mdrIn, mdrOut, cOut, incPc, read} = '0;
        opcode = '0;
    endtask

    task automatic nextCycle();
        @(negedge Clock);
        clearStrobes();
    endtask

    task automatic selectReg(input int which);
        gra = (which == 0);
        grb = (which == 1);
        grc = (which == 2);
    endtask

    task automatic expectBus(input string name, input logic [31:0] expected);
        #10;
        assert (busData == expected)
            else reportMismatch({"busData with ", name}, busData, expected);
    endtask

    // read was pulsed in the current cycle.
    task automatic waitForRead(input logic [31:0] addr);
        int cycles;
        cycles = 0;
        nextCycle();
        assert (memBusy) else reportMismatch("memBusy", 32'(memBusy), 32'd1);
        while (memBusy) begin
            assert (wbAdr == addr) else reportMismatch("wbAdr", wbAdr, addr);
            if (cycles == readTimeout) begin
                $display("ERROR at %0t ns: memory read did not finish in time", $time);
                $display("SIMULATION FAILED");
                $fatal(1, "read timeout");
            end
            cycles++;
            @(negedge Clock);
        end
    endtask

    task automatic fetchWord(output logic [31:0] word);
        logic [31:0] oldPc;
        oldPc = pcModel;
        nextCycle();
        {pcOut, marIn, incPc, zIn} = 4'b1111;
        expectBus("pcOut", oldPc);
        nextCycle();
        {zLowOut, pcIn, read} = 3'b111;
        expectBus("zLowOut", oldPc + 1);
        pcModel = oldPc + 1;
        waitForRead(oldPc);
        word = memWord(oldPc);
    endtask

    // wishbone slave.
    always @(negedge Clock) begin
        if (!wbCyc) begin
            wbAck = 1'b0;
            ackDelay = $urandom % 4;
        end else if (!wbAck && ackDelay > 0) begin
            ackDelay--;
        end else if (!wbAck) begin
            wbAck = 1'b1;
            wbDatIn = memWord(wbAdr);
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] instr;
        logic [63:0] expected;
        void'($urandom(32'hb3a8_e8fc));
        rstN = 1'b0;
        clearStrobes();
        instr = {datapathPkg::opAdd, 4'd5, 4'd9, 4'd12, 15'($urandom)};   // negative constant.
        preload[5] = instr;
        for (int i = 0; i < 3; i++) begin
            preload[6 + i] = $urandom;
        end
        repeat (4) @(negedge Clock);
        rstN = 1'b1;

        nextCycle();
        pcOut = 1'b1;
        assert (!wbCyc && !wbStb && !memBusy)
            else reportMismatch("wbCyc,wbStb,memBusy", {29'b0, wbCyc, wbStb, memBusy}, '0);
        expectBus("pcOut", '0);

        for (int i = 0; i < 6; i++) begin   // last fetch leaves instr in IR.
            fetchWord(word);
            nextCycle();
            {mdrOut, irIn} = 2'b11;
            expectBus("mdrOut", word);
        end
        for (int r = 0; r < 3; r++) begin
            fetchWord(regModel[r]);
            nextCycle();
            {mdrOut, rIn} = 2'b11;
            selectReg(r);
            expectBus("mdrOut", regModel[r]);
        end
        for (int r = 0; r < 3; r++) begin
            nextCycle();
            rOut = 1'b1;
            selectReg(r);
            expectBus("rOut", regModel[r]);
        end
        nextCycle();
        cOut = 1'b1;
        expectBus("cOut", {{13{instr[18]}}, instr[18:0]});

        foreach (opList[k]) begin
            for (int p = 0; p < 3; p++) begin
                nextCycle();
                {rOut, yIn} = 2'b11;
                selectReg(p);
                nextCycle();
                {rOut, zIn} = 2'b11;
                selectReg((p + 1) % 3);
                opcode = opList[k];
                expected = aluModel(opList[k], regModel[p], regModel[(p + 1) % 3]);
                nextCycle();
                zLowOut = 1'b1;
                expectBus("zLowOut", expected[31:0]);
                nextCycle();
                zHighOut = 1'b1;
                expectBus("zHighOut", expected[63:32]);
            end
        end

        for (int c = 0; c < 2; c++) begin
            nextCycle();
            {rOut, yIn} = 2'b11;
            selectReg(2);
            nextCycle();
            rOut = (c == 0);   // div sees the idle, all-zero bus.
            selectReg(0);
            zIn = 1'b1;
            opcode = (c == 0) ? datapathPkg::opMul : datapathPkg::opDiv;
            expected = aluModel(opcode, regModel[2], (c == 0) ? regModel[0] : '0);
            nextCycle();
            {zHighOut, hiIn} = 2'b11;
            expectBus("zHighOut", expected[63:32]);
            nextCycle();
            {zLowOut, loIn} = 2'b11;
            expectBus("zLowOut", expected[31:0]);
            nextCycle();
            hiOut = 1'b1;
            expectBus("hiOut", expected[63:32]);
            nextCycle();
            loOut = 1'b1;
            expectBus("loOut", expected[31:0]);
        end

        nextCycle();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/datapath_chk.sv
`timescale 1ns/1ps
`default_nettype none

module datapathChk (
    input logic Clock,
    input logic rstN,
    input logic rOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, cOut,
    input logic gra, grb, grc,
    input logic read,
    input logic wbCyc,
    input logic wbStb,
    input logic [31:0] wbAdr,
    input logic memBusy
);

    busOneDriver: assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0({rOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, cOut}))
        else $error("more than one bus driver enabled");

    oneFieldSelect: assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0({gra, grb, grc})) else $error("more than one register field selected");

    stbFollowsCyc: assert property (@(posedge Clock) disable iff (!rstN)
        wbStb == wbCyc) else $error("wbStb differs from wbCyc");

    // address held for the whole cycle.
    adrStable: assert property (@(posedge Clock) disable iff (!rstN)
        wbCyc && $past(wbCyc) |-> wbAdr == $past(wbAdr)) else $error("wbAdr moved during a read");

    noReadWhileBusy: assert property (@(posedge Clock) disable iff (!rstN)
        memBusy |-> !read) else $error("read pulsed while memory busy");

endmodule

bind datapath datapathChk protocolChecks (
    .Clock(Clock), .rstN(rstN), .rOut(rOut), .pcOut(pcOut), .mdrOut(mdrOut),
    .zHighOut(zHighOut), .zLowOut(zLowOut), .hiOut(hiOut), .loOut(loOut), .cOut(cOut),
    .gra(gra), .grb(grb), .grc(grc), .read(read), .wbCyc(wbCyc), .wbStb(wbStb),
    .wbAdr(wbAdr), .memBusy(memBusy)
);

`default_nettype wire

//--- source/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic Clock,
    input  logic rstN,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic rIn,
    input  logic rOut,
    input  logic pcIn,
    input  logic pcOut,
    input  logic irIn,
    input  logic yIn,
    input  logic zIn,
    input  logic zHighOut,
    input  logic zLowOut,
    input  logic hiIn,
    input  logic hiOut,
    input  logic loIn,
    input  logic loOut,
    input  logic marIn,
    input  logic mdrIn,
    input  logic mdrOut,
    input  logic cOut,
    input  logic incPc,
    input  logic read,
    input  logic [datapathPkg::opcodeWidth-1:0] opcode,
    input  logic [datapathPkg::dataWidth-1:0] wbDatIn,
    input  logic wbAck,
    output logic [datapathPkg::dataWidth-1:0] busData,
    output logic wbCyc,
    output logic wbStb,
    output logic [datapathPkg::dataWidth-1:0] wbAdr,
    output logic memBusy
);
    logic [datapathPkg::regCount-1:0] regLoad;
    logic [datapathPkg::regIndexWidth-1:0] regDrive;
    logic [datapathPkg::dataWidth-1:0] cValue;
    logic [datapathPkg::dataWidth-1:0] regData;
    logic [datapathPkg::dataWidth-1:0] pcValue;
    datapathPkg::instrWord ir;
    logic [datapathPkg::dataWidth-1:0] yValue;
    logic [2*datapathPkg::dataWidth-1:0] zValue;
    logic [2*datapathPkg::dataWidth-1:0] aluResult;
    logic [datapathPkg::dataWidth-1:0] hiValue;
    logic [datapathPkg::dataWidth-1:0] loValue;
    logic [datapathPkg::dataWidth-1:0] mdrValue;

    selectEncode selectEncode (
        .ir(ir), .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
        .regLoad(regLoad), .regDrive(regDrive), .cValue(cValue)
    );

    registerFile registerFile (
        .Clock(Clock), .rstN(rstN), .regLoad(regLoad), .regDrive(regDrive),
        .busData(busData), .regData(regData)
    );

    busMux busMux (
        .rOut(rOut), .regData(regData), .pcOut(pcOut), .pcValue(pcValue),
        .mdrOut(mdrOut), .mdrValue(mdrValue), .zHighOut(zHighOut), .zLowOut(zLowOut),
        .zValue(zValue), .hiOut(hiOut), .hiValue(hiValue), .loOut(loOut),
        .loValue(loValue), .cOut(cOut), .cValue(cValue), .busData(busData)
    );

    alu alu (
        .yValue(yValue), .busData(busData), .opcode(opcode), .incPc(incPc),
        .result(aluResult)
    );

    specialRegisters specialRegisters (
        .Clock(Clock), .rstN(rstN), .busData(busData), .aluResult(aluResult),
        .pcIn(pcIn), .irIn(irIn), .yIn(yIn), .zIn(zIn), .hiIn(hiIn), .loIn(loIn),
        .pcValue(pcValue), .ir(ir), .yValue(yValue), .zValue(zValue),
        .hiValue(hiValue), .loValue(loValue)
    );

    memoryInterface memoryInterface (
        .Clock(Clock), .rstN(rstN), .busData(busData), .marIn(marIn), .mdrIn(mdrIn),
        .read(read), .wbDatIn(wbDatIn), .wbAck(wbAck), .mdrValue(mdrValue),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .memBusy(memBusy)
    );

endmodule

`default_nettype wire

//--- source/memoryInterface.sv
`timescale 1ns/1ps
`default_nettype none

module memoryInterface (
    input  logic Clock,
    input  logic rstN,
    input  logic [datapathPkg::dataWidth-1:0] busData,
    input  logic marIn,
    input  logic mdrIn,
    input  logic read,
    input  logic [datapathPkg::dataWidth-1:0] wbDatIn,
    input  logic wbAck,
    output logic [datapathPkg::dataWidth-1:0] mdrValue,
    output logic wbCyc,
    output logic wbStb,
    output logic [datapathPkg::dataWidth-1:0] wbAdr,
    output logic memBusy
);
    logic [datapathPkg::dataWidth-1:0] mar;
    logic waiting;   // low is idle.

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            waiting <= 1'b0;
        end else if (!waiting && read) begin
            waiting <= 1'b1;
        end else if (waiting && wbAck) begin
            waiting <= 1'b0;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mar <= '0;
            mdrValue <= '0;
        end else begin
            if (marIn) mar <= busData;
            if (waiting && wbAck) mdrValue <= wbDatIn;   // ack beats a bus load.
            else if (mdrIn) mdrValue <= busData;
        end
    end

    assign wbCyc = waiting;
    assign wbStb = waiting;
    assign wbAdr = mar;
    assign memBusy = waiting;

endmodule

`default_nettype wire

//--- source/specialRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module specialRegisters (
    input  logic Clock,
    input  logic rstN,
    input  logic [datapathPkg::dataWidth-1:0] busData,
    input  logic [2*datapathPkg::dataWidth-1:0] aluResult,
    input  logic pcIn,
    input  logic irIn,
    input  logic yIn,
    input  logic zIn,
    input  logic hiIn,
    input  logic loIn,
    output logic [datapathPkg::dataWidth-1:0] pcValue,
    output datapathPkg::instrWord ir,
    output logic [datapathPkg::dataWidth-1:0] yValue,
    output logic [2*datapathPkg::dataWidth-1:0] zValue,
    output logic [datapathPkg::dataWidth-1:0] hiValue,
    output logic [datapathPkg::dataWidth-1:0] loValue
);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pcValue <= '0;
            ir <= '0;
            yValue <= '0;
            zValue <= '0;
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (pcIn) pcValue <= busData;
            if (irIn) ir <= busData;
            if (yIn) yValue <= busData;     // alu operand a.
            if (zIn) zValue <= aluResult;   // only z loads from the alu.
            if (hiIn) hiValue <= busData;
            if (loIn) loValue <= busData;
        end
    end

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [datapathPkg::dataWidth-1:0] yValue,
    input  logic [datapathPkg::dataWidth-1:0] busData,
    input  logic [datapathPkg::opcodeWidth-1:0] opcode,
    input  logic incPc,
    output logic [2*datapathPkg::dataWidth-1:0] result
);
    localparam int dw = datapathPkg::dataWidth;

    logic [$clog2(dw)-1:0] shiftAmount;
    logic [2*dw-1:0] doubled;
    logic [2*dw-1:0] rotRight;
    logic [2*dw-1:0] rotLeft;
    logic signed [dw-1:0] quotient;
    logic signed [dw-1:0] remainder;

    assign shiftAmount = busData[$clog2(dw)-1:0];
    assign doubled = {yValue, yValue};
    assign rotRight = doubled >> shiftAmount;
    assign rotLeft = doubled << shiftAmount;

    always_comb begin
        if (busData == '0) begin
            quotient = '1;             // divide by zero.
            remainder = yValue;
        end else if (busData == '1) begin
            quotient = -yValue;        // avoids the min / -1 overflow trap.
            remainder = '0;
        end else begin
            quotient = $signed(yValue) / $signed(busData);
            remainder = $signed(yValue) % $signed(busData);
        end
    end

    always_comb begin
        result = '0;
        if (incPc) begin
            result[dw-1:0] = busData + 1;
        end else begin
            case (opcode)
                datapathPkg::opAdd: result[dw-1:0] = yValue + busData;
                datapathPkg::opSub: result[dw-1:0] = yValue - busData;
                datapathPkg::opAnd: result[dw-1:0] = yValue & busData;
                datapathPkg::opOr: result[dw-1:0] = yValue | busData;
                datapathPkg::opShr: result[dw-1:0] = yValue >> shiftAmount;
                datapathPkg::opShra: result[dw-1:0] = $signed(yValue) >>> shiftAmount;
                datapathPkg::opShl: result[dw-1:0] = yValue << shiftAmount;
                datapathPkg::opRor: result[dw-1:0] = rotRight[dw-1:0];
                datapathPkg::opRol: result[dw-1:0] = rotLeft[2*dw-1:dw];
                // signed product from sign-extended operands.
                datapathPkg::opMul: result = {{dw{yValue[dw-1]}}, yValue}
                                           * {{dw{busData[dw-1]}}, busData};
                datapathPkg::opDiv: result = {remainder, quotient};
                datapathPkg::opNeg: result[dw-1:0] = -busData;
                datapathPkg::opNot: result[dw-1:0] = ~busData;
                default: result = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux (
    input  logic rOut,
    input  logic [datapathPkg::dataWidth-1:0] regData,
    input  logic pcOut,
    input  logic [datapathPkg::dataWidth-1:0] pcValue,
    input  logic mdrOut,
    input  logic [datapathPkg::dataWidth-1:0] mdrValue,
    input  logic zHighOut,
    input  logic zLowOut,
    input  logic [2*datapathPkg::dataWidth-1:0] zValue,
    input  logic hiOut,
    input  logic [datapathPkg::dataWidth-1:0] hiValue,
    input  logic loOut,
    input  logic [datapathPkg::dataWidth-1:0] loValue,
    input  logic cOut,
    input  logic [datapathPkg::dataWidth-1:0] cValue,
    output logic [datapathPkg::dataWidth-1:0] busData
);
    localparam int dw = datapathPkg::dataWidth;

    // and-or select over one-hot strobes gives zero when none is high.
    assign busData = ({dw{rOut}} & regData)
                   | ({dw{pcOut}} & pcValue)
                   | ({dw{mdrOut}} & mdrValue)
                   | ({dw{zHighOut}} & zValue[2*dw-1:dw])
                   | ({dw{zLowOut}} & zValue[dw-1:0])
                   | ({dw{hiOut}} & hiValue)
                   | ({dw{loOut}} & loValue)
                   | ({dw{cOut}} & cValue);

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic Clock,
    input  logic rstN,
    input  logic [datapathPkg::regCount-1:0] regLoad,
    input  logic [datapathPkg::regIndexWidth-1:0] regDrive,
    input  logic [datapathPkg::dataWidth-1:0] busData,
    output logic [datapathPkg::dataWidth-1:0] regData
);
    logic [datapathPkg::dataWidth-1:0] regs [datapathPkg::regCount];

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < datapathPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < datapathPkg::regCount; i++) begin
                if (regLoad[i]) begin
                    regs[i] <= busData;
                end
            end
        end
    end

    assign regData = regs[regDrive];   // async read port.

endmodule

`default_nettype wire

//--- source/selectEncode.sv
`timescale 1ns/1ps
`default_nettype none

module selectEncode (
    input  datapathPkg::instrWord ir,
    input  logic gra,
    input  logic grb,
    input  logic grc,
    input  logic rIn,
    input  logic rOut,
    output logic [datapathPkg::regCount-1:0] regLoad,
    output logic [datapathPkg::regIndexWidth-1:0] regDrive,
    output logic [datapathPkg::dataWidth-1:0] cValue
);
    logic [datapathPkg::regIndexWidth-1:0] field;
    logic fieldValid;

    always_comb begin
        fieldValid = gra | grb | grc;
        field = '0;
        if (gra) field = ir.rFormat.ra;
        else if (grb) field = ir.rFormat.rb;
        else if (grc) field = ir.rFormat.rc;
    end

    always_comb begin
        regLoad = '0;
        if (rIn && fieldValid) begin
            regLoad[field] = 1'b1;   // one-hot write enable.
        end
    end

    assign regDrive = rOut ? field : '0;

    // constant field sign-extended to bus width.
    assign cValue = {{(datapathPkg::dataWidth - datapathPkg::constWidth)
                      {ir.iFormat.constant[datapathPkg::constWidth-1]}},
                     ir.iFormat.constant};

endmodule

`default_nettype wire

//--- source/datapathPkg.sv
`default_nettype none

package datapathPkg;

    localparam int dataWidth = 32;     // width of the shared bus.
    localparam int regCount = 16;
    localparam int regIndexWidth = 4;
    localparam int opcodeWidth = 5;
    localparam int constWidth = 19;

    // alu opcodes in the top five bits of the instruction.
    localparam logic [opcodeWidth-1:0] opAdd = 5'b00011;
    localparam logic [opcodeWidth-1:0] opSub = 5'b00100;
    localparam logic [opcodeWidth-1:0] opAnd = 5'b00101;
    localparam logic [opcodeWidth-1:0] opOr = 5'b00110;
    localparam logic [opcodeWidth-1:0] opShr = 5'b00111;
    localparam logic [opcodeWidth-1:0] opShra = 5'b01000;
    localparam logic [opcodeWidth-1:0] opShl = 5'b01001;
    localparam logic [opcodeWidth-1:0] opRor = 5'b01010;
    localparam logic [opcodeWidth-1:0] opRol = 5'b01011;
    localparam logic [opcodeWidth-1:0] opMul = 5'b01110;
    localparam logic [opcodeWidth-1:0] opDiv = 5'b01111;
    localparam logic [opcodeWidth-1:0] opNeg = 5'b10000;
    localparam logic [opcodeWidth-1:0] opNot = 5'b10001;

    // one instruction word read in three-register or register-constant form.
    typedef union packed {
        struct packed {
            logic [opcodeWidth-1:0] opcode;
            logic [regIndexWidth-1:0] ra;
            logic [regIndexWidth-1:0] rb;
            logic [regIndexWidth-1:0] rc;
            logic [dataWidth-opcodeWidth-3*regIndexWidth-1:0] unused;
        } rFormat;
        struct packed {
            logic [opcodeWidth-1:0] opcode;
            logic [regIndexWidth-1:0] ra;
            logic [regIndexWidth-1:0] rb;
            logic [constWidth-1:0] constant;
        } iFormat;
    } instrWord;

endpackage

`default_nettype wire
